// ==== verilog/mvdm_config.svh ====
`ifndef MVDM_CONFIG_SVH
`define MVDM_CONFIG_SVH

// Image store
`define MVDM_IMG_DIM    32
`define MVDM_IMG_AW     10
`define MVDM_PIX_W      8
`define MVDM_WORD_W     12
`define MVDM_FRAC_W     4

// Interpolated block buffers
`define MVDM_BLK_DIM    10
`define MVDM_BLK_AW     7
`define MVDM_BI_W       16

// Search and result
`define MVDM_SAD_DIM    8
`define MVDM_SEARCH_N   9
`define MVDM_SAD_W      24
`define MVDM_IDX_W      4
`define MVDM_RESULT_W   28

`endif

// ==== verilog/mvdm_pkg.sv ====
`include "mvdm_config.svh"

package mvdm_pkg;

    // Image load word, pixel in the upper byte
    typedef struct packed {
        logic [`MVDM_PIX_W-1:0]              pix;
        logic [`MVDM_WORD_W-`MVDM_PIX_W-1:0] unused;
    } pixel_view_s;

    // Motion vector word, one component
    typedef struct packed {
        logic                                  spare;
        logic [`MVDM_WORD_W-`MVDM_FRAC_W-2:0]  int_pos;
        logic [`MVDM_FRAC_W-1:0]               frac;
    } mv_view_s;

    typedef union packed {
        pixel_view_s pixel_view;
        mv_view_s    mv_view;
    } in_word_u;

    typedef struct packed {
        logic [`MVDM_WORD_W-`MVDM_FRAC_W-2:0] int_x;
        logic [`MVDM_WORD_W-`MVDM_FRAC_W-2:0] int_y;
        logic [`MVDM_FRAC_W-1:0]              frac_x;
        logic [`MVDM_FRAC_W-1:0]              frac_y;
    } mv_s;

    typedef struct packed {
        logic [`MVDM_IMG_AW-1:0] addr;
        logic [`MVDM_PIX_W-1:0]  wdata;
        logic                    we;
    } img_req_s;

    typedef struct packed {
        logic [`MVDM_BLK_AW-1:0] addr;
        logic [`MVDM_BI_W-1:0]   wdata;
        logic                    we;
    } bi_req_s;

    typedef struct packed {
        logic                   sample_valid;
        logic                   point_first;
        logic                   point_last;
        logic [`MVDM_IDX_W-1:0] point_idx;
    } sad_ctl_s;

    typedef enum logic [2:0] {IDLE, LOAD_IMG, LOAD_MV, INTERP, SAD, REPORT} mvdm_state_e;

endpackage

// ==== verilog/pixel_ram.sv ====
`timescale 1ns/1ps

module pixel_ram #(
    parameter int DATA_W = 8,
    parameter int ADDR_W = 10
) (
    input  logic                   clk,
    input  logic [ADDR_W+DATA_W:0] req,    // {addr, wdata, we}
    output logic [DATA_W-1:0]      rdata
);
    logic [DATA_W-1:0] mem [0:(1<<ADDR_W)-1];
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    assign addr  = req[ADDR_W+DATA_W -: ADDR_W];
    assign wdata = req[DATA_W:1];

    always_ff @(posedge clk) begin
        if (req[0]) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];    // Old data on write
    end

endmodule

// ==== verilog/mvdm_ctrl.sv ====
`timescale 1ns/1ps
`include "mvdm_config.svh"

module mvdm_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   in_valid2,
    input  mvdm_pkg::in_word_u     in_data,
    input  logic [`MVDM_PIX_W-1:0] img_rdata0,
    input  logic [`MVDM_PIX_W-1:0] img_rdata1,
    input  mvdm_pkg::bi_req_s      bi_wr0,
    input  mvdm_pkg::bi_req_s      bi_wr1,
    output mvdm_pkg::img_req_s     img_req0,
    output mvdm_pkg::img_req_s     img_req1,
    output logic [`MVDM_PIX_W-1:0] pix0,
    output logic [`MVDM_PIX_W-1:0] pix1,
    output logic                   pix_valid,
    output logic                   interp_start,
    output mvdm_pkg::mv_s          mv0,
    output mvdm_pkg::mv_s          mv1,
    output mvdm_pkg::bi_req_s      bi_rd_addr0,
    output mvdm_pkg::bi_req_s      bi_rd_addr1,
    output mvdm_pkg::sad_ctl_s     sad_ctl,
    output logic                   report_go
);
    localparam int LOAD_LAST = 2 * `MVDM_IMG_DIM * `MVDM_IMG_DIM - 1;
    localparam int WIN       = `MVDM_BLK_DIM + 1;
    localparam int SAMPLES   = `MVDM_SAD_DIM * `MVDM_SAD_DIM;

    mvdm_pkg::mvdm_state_e state;

    logic [10:0] cnt;      // Load word, MV word, drain, sample or report count
    logic [3:0]  row;
    logic [3:0]  col;
    logic [3:0]  pt;
    logic [1:0]  px;
    logic [1:0]  py;
    logic        load_we;
    logic        mv_we;
    logic        rd_en;
    logic        samp_en;

    function automatic logic [`MVDM_IMG_AW-1:0] win_addr(mvdm_pkg::mv_s mv, logic [3:0] r,
                                                          logic [3:0] c);
        logic [`MVDM_IMG_AW-1:0] a;
        a = (mv.int_y + r) * `MVDM_IMG_DIM + mv.int_x + c;
        return a;
    endfunction

    function automatic logic [`MVDM_BLK_AW-1:0] blk_addr(logic [3:0] r, logic [3:0] c);
        logic [`MVDM_BLK_AW-1:0] a;
        a = r * `MVDM_BLK_DIM + c;
        return a;
    endfunction

    assign load_we = in_valid && (state == mvdm_pkg::IDLE || state == mvdm_pkg::LOAD_IMG);
    assign mv_we   = in_valid2 && ((state == mvdm_pkg::IDLE && !in_valid) ||
                                   state == mvdm_pkg::LOAD_MV);
    assign rd_en   = (state == mvdm_pkg::INTERP) && (row != WIN);
    assign samp_en = (state == mvdm_pkg::SAD) && (cnt != SAMPLES);

    //==========================================================================
    //  Memory ports
    //==========================================================================
    assign img_req0 = '{addr:  load_we ? cnt[`MVDM_IMG_AW-1:0] : win_addr(mv0, row, col),
                        wdata: in_data.pixel_view.pix,
                        we:    load_we && !cnt[`MVDM_IMG_AW]};
    assign img_req1 = '{addr:  load_we ? cnt[`MVDM_IMG_AW-1:0] : win_addr(mv1, row, col),
                        wdata: in_data.pixel_view.pix,
                        we:    load_we && cnt[`MVDM_IMG_AW]};

    assign pix0 = img_rdata0;
    assign pix1 = img_rdata1;

    // Mirrored search, list 1 walks the opposite way
    assign bi_rd_addr0 = (state == mvdm_pkg::SAD) ?
        mvdm_pkg::bi_req_s'{addr: blk_addr(py + cnt[5:3], px + cnt[2:0]), wdata: '0, we: 1'b0} :
        bi_wr0;
    assign bi_rd_addr1 = (state == mvdm_pkg::SAD) ?
        mvdm_pkg::bi_req_s'{addr:  blk_addr(4'd2 - py + cnt[5:3], 4'd2 - px + cnt[2:0]),
                            wdata: '0,
                            we:    1'b0} :
        bi_wr1;

    //==========================================================================
    //  FSM and counters
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= mvdm_pkg::IDLE;
            cnt          <= '0;
            row          <= '0;
            col          <= '0;
            pt           <= '0;
            px           <= '0;
            py           <= '0;
            pix_valid    <= 1'b0;
            interp_start <= 1'b0;
            report_go    <= 1'b0;
            sad_ctl      <= '0;
        end else begin
            pix_valid            <= rd_en;    // Matches RAM latency
            interp_start         <= 1'b0;
            report_go            <= 1'b0;
            sad_ctl.sample_valid <= samp_en;
            sad_ctl.point_first  <= samp_en && cnt[5:0] == 6'd0;
            sad_ctl.point_last   <= samp_en && cnt[5:0] == 6'(SAMPLES - 1);
            sad_ctl.point_idx    <= pt;
            case (state)
                mvdm_pkg::IDLE: begin
                    if (in_valid) begin
                        cnt   <= 11'd1;
                        state <= mvdm_pkg::LOAD_IMG;
                    end else if (in_valid2) begin
                        cnt   <= 11'd1;
                        state <= mvdm_pkg::LOAD_MV;
                    end
                end
                mvdm_pkg::LOAD_IMG: begin
                    if (in_valid) begin
                        cnt <= cnt + 11'd1;    // Wraps to 0 after the last word
                        if (cnt == LOAD_LAST) begin
                            state <= mvdm_pkg::IDLE;
                        end
                    end
                end
                mvdm_pkg::LOAD_MV: begin
                    if (in_valid2) begin
                        if (cnt == 11'd3) begin
                            cnt          <= '0;
                            interp_start <= 1'b1;
                            state        <= mvdm_pkg::INTERP;
                        end else begin
                            cnt <= cnt + 11'd1;
                        end
                    end
                end
                mvdm_pkg::INTERP: begin
                    if (row != WIN) begin
                        if (col == WIN - 1) begin
                            col <= '0;
                            row <= row + 4'd1;
                        end else begin
                            col <= col + 4'd1;
                        end
                    end else if (cnt == 11'd2) begin    // Drain pixel and write stages
                        cnt   <= '0;
                        row   <= '0;
                        state <= mvdm_pkg::SAD;
                    end else begin
                        cnt <= cnt + 11'd1;
                    end
                end
                mvdm_pkg::SAD: begin
                    if (cnt == SAMPLES) begin
                        cnt <= '0;
                        if (pt == `MVDM_SEARCH_N - 1) begin
                            pt        <= '0;
                            px        <= '0;
                            py        <= '0;
                            report_go <= 1'b1;
                            state     <= mvdm_pkg::REPORT;
                        end else begin
                            pt <= pt + 4'd1;
                            if (px == 2'd2) begin
                                px <= '0;
                                py <= py + 2'd1;
                            end else begin
                                px <= px + 2'd1;
                            end
                        end
                    end else begin
                        cnt <= cnt + 11'd1;
                    end
                end
                mvdm_pkg::REPORT: begin
                    if (cnt == `MVDM_RESULT_W) begin    // Serial burst done
                        cnt   <= '0;
                        state <= mvdm_pkg::IDLE;
                    end else begin
                        cnt <= cnt + 11'd1;
                    end
                end
                default: state <= mvdm_pkg::IDLE;
            endcase
        end
    end

    // MV words arrive as L0 x, L0 y, L1 x, L1 y
    always_ff @(posedge clk) begin
        if (mv_we) begin
            case (cnt[1:0])
                2'd0: begin
                    mv0.int_x  <= in_data.mv_view.int_pos;
                    mv0.frac_x <= in_data.mv_view.frac;
                end
                2'd1: begin
                    mv0.int_y  <= in_data.mv_view.int_pos;
                    mv0.frac_y <= in_data.mv_view.frac;
                end
                2'd2: begin
                    mv1.int_x  <= in_data.mv_view.int_pos;
                    mv1.frac_x <= in_data.mv_view.frac;
                end
                default: begin
                    mv1.int_y  <= in_data.mv_view.int_pos;
                    mv1.frac_y <= in_data.mv_view.frac;
                end
            endcase
        end
    end

endmodule

// ==== verilog/bilinear_interp.sv ====
`timescale 1ns/1ps
`include "mvdm_config.svh"

module bilinear_interp (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  mvdm_pkg::mv_s          mv,
    input  logic [`MVDM_PIX_W-1:0] pix,
    input  logic                   pix_valid,
    output mvdm_pkg::bi_req_s      bi_wr
);
    localparam int WIN = `MVDM_BLK_DIM + 1;

    logic [8:0]              w [0:3];
    logic [`MVDM_FRAC_W:0]   fx_c;
    logic [`MVDM_FRAC_W:0]   fy_c;
    logic [`MVDM_PIX_W-1:0]  row_buf [0:WIN-1];    // Previous window row
    logic [`MVDM_PIX_W-1:0]  prev_pix;
    logic [`MVDM_PIX_W-1:0]  top_left;
    logic [3:0]              row;
    logic [3:0]              col;
    logic [`MVDM_BI_W-1:0]   mac;
    logic [`MVDM_BLK_AW-1:0] wr_addr;

    assign fx_c = (1 << `MVDM_FRAC_W) - mv.frac_x;
    assign fy_c = (1 << `MVDM_FRAC_W) - mv.frac_y;

    // 2x2 neighborhood, full precision
    assign mac = w[0] * top_left + w[1] * row_buf[col] + w[2] * prev_pix + w[3] * pix;

    assign wr_addr = (row - 1) * `MVDM_BLK_DIM + col - 1;

    always_ff @(posedge clk) begin
        if (start) begin
            w[0] <= fx_c * fy_c;
            w[1] <= mv.frac_x * fy_c;
            w[2] <= fx_c * mv.frac_y;
            w[3] <= mv.frac_x * mv.frac_y;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            row_buf[col] <= pix;
            top_left     <= row_buf[col];
            prev_pix     <= pix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (start) begin
            row <= '0;
            col <= '0;
        end else if (pix_valid) begin
            if (col == WIN - 1) begin
                col <= '0;
                row <= row + 4'd1;
            end else begin
                col <= col + 4'd1;
            end
        end
    end

    // First window row and column only prime the buffers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bi_wr <= '0;
        end else begin
            bi_wr.we    <= pix_valid && row != 4'd0 && col != 4'd0;
            bi_wr.addr  <= wr_addr;
            bi_wr.wdata <= mac;
        end
    end

endmodule

// ==== verilog/sad_search.sv ====
`timescale 1ns/1ps
`include "mvdm_config.svh"

module sad_search (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mvdm_pkg::sad_ctl_s    sad_ctl,
    input  logic [`MVDM_BI_W-1:0] bi_rdata0,
    input  logic [`MVDM_BI_W-1:0] bi_rdata1,
    input  logic                  report_go,
    output logic                  out_valid,
    output logic                  out_sad
);
    logic [`MVDM_BI_W-1:0]     abs_diff;
    logic [`MVDM_SAD_W-1:0]    acc;
    logic [`MVDM_SAD_W-1:0]    cand;
    logic [`MVDM_SAD_W-1:0]    min_sad;
    logic [`MVDM_IDX_W-1:0]    min_idx;
    logic [`MVDM_RESULT_W-1:0] result;
    logic [`MVDM_RESULT_W-1:0] shift;
    logic [4:0]                bits_left;

    assign abs_diff = (bi_rdata0 > bi_rdata1) ? bi_rdata0 - bi_rdata1 : bi_rdata1 - bi_rdata0;
    assign cand     = (sad_ctl.point_first ? '0 : acc) + abs_diff;
    assign result   = {min_idx, min_sad};

    //==========================================================================
    //  Accumulate and track minimum
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc     <= '0;
            min_sad <= '1;
            min_idx <= '0;
        end else if (sad_ctl.sample_valid) begin
            acc <= cand;
            if (sad_ctl.point_first && sad_ctl.point_idx == '0) begin
                min_sad <= '1;    // New search
            end
            if (sad_ctl.point_last && cand < min_sad) begin    // Ties keep earlier point
                min_sad <= cand;
                min_idx <= sad_ctl.point_idx;
            end
        end
    end

    //==========================================================================
    //  Serial result, LSB first
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
            shift     <= '0;
            bits_left <= '0;
        end else if (report_go) begin
            out_valid <= 1'b1;
            out_sad   <= result[0];
            shift     <= result >> 1;
            bits_left <= 5'(`MVDM_RESULT_W - 1);
        end else if (bits_left != '0) begin
            out_valid <= 1'b1;
            out_sad   <= shift[0];
            shift     <= shift >> 1;
            bits_left <= bits_left - 5'd1;
        end else begin
            out_valid <= 1'b0;
            out_sad   <= 1'b0;
        end
    end

endmodule

// ==== verilog/mvdm_top.sv ====
`timescale 1ns/1ps
`include "mvdm_config.svh"

module mvdm_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_valid2,
    input  mvdm_pkg::in_word_u in_data,
    output logic               out_valid,
    output logic               out_sad
);
    mvdm_pkg::img_req_s     img_req0;
    mvdm_pkg::img_req_s     img_req1;
    logic [`MVDM_PIX_W-1:0] img_rdata0;
    logic [`MVDM_PIX_W-1:0] img_rdata1;
    logic [`MVDM_PIX_W-1:0] pix0;
    logic [`MVDM_PIX_W-1:0] pix1;
    logic                   pix_valid;
    logic                   interp_start;
    mvdm_pkg::mv_s          mv0;
    mvdm_pkg::mv_s          mv1;
    mvdm_pkg::bi_req_s      bi_wr0;
    mvdm_pkg::bi_req_s      bi_wr1;
    mvdm_pkg::bi_req_s      bi_port0;    // Write from interp or SAD read
    mvdm_pkg::bi_req_s      bi_port1;
    logic [`MVDM_BI_W-1:0]  bi_rdata0;
    logic [`MVDM_BI_W-1:0]  bi_rdata1;
    mvdm_pkg::sad_ctl_s     sad_ctl;
    logic                   report_go;

    mvdm_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_valid2    (in_valid2),
        .in_data      (in_data),
        .img_rdata0   (img_rdata0),
        .img_rdata1   (img_rdata1),
        .bi_wr0       (bi_wr0),
        .bi_wr1       (bi_wr1),
        .img_req0     (img_req0),
        .img_req1     (img_req1),
        .pix0         (pix0),
        .pix1         (pix1),
        .pix_valid    (pix_valid),
        .interp_start (interp_start),
        .mv0          (mv0),
        .mv1          (mv1),
        .bi_rd_addr0  (bi_port0),
        .bi_rd_addr1  (bi_port1),
        .sad_ctl      (sad_ctl),
        .report_go    (report_go)
    );

    pixel_ram #(.DATA_W(`MVDM_PIX_W), .ADDR_W(`MVDM_IMG_AW)) u_img0 (
        .clk   (clk),
        .req   (img_req0),
        .rdata (img_rdata0)
    );

    pixel_ram #(.DATA_W(`MVDM_PIX_W), .ADDR_W(`MVDM_IMG_AW)) u_img1 (
        .clk   (clk),
        .req   (img_req1),
        .rdata (img_rdata1)
    );

    pixel_ram #(.DATA_W(`MVDM_BI_W), .ADDR_W(`MVDM_BLK_AW)) u_bi0 (
        .clk   (clk),
        .req   (bi_port0),
        .rdata (bi_rdata0)
    );

    pixel_ram #(.DATA_W(`MVDM_BI_W), .ADDR_W(`MVDM_BLK_AW)) u_bi1 (
        .clk   (clk),
        .req   (bi_port1),
        .rdata (bi_rdata1)
    );

    bilinear_interp u_interp0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (interp_start),
        .mv        (mv0),
        .pix       (pix0),
        .pix_valid (pix_valid),
        .bi_wr     (bi_wr0)
    );

    bilinear_interp u_interp1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (interp_start),
        .mv        (mv1),
        .pix       (pix1),
        .pix_valid (pix_valid),
        .bi_wr     (bi_wr1)
    );

    sad_search u_sad (
        .clk       (clk),
        .rst_n     (rst_n),
        .sad_ctl   (sad_ctl),
        .bi_rdata0 (bi_rdata0),
        .bi_rdata1 (bi_rdata1),
        .report_go (report_go),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

endmodule

// ==== tb/mvdm_model.svh ====
`ifndef MVDM_MODEL_SVH
`define MVDM_MODEL_SVH

// Reference model, reads the testbench image copies img0 and img1

function automatic int ref_pixel(int list, int y, int x);
    if (list == 0) begin
        return int'(img0[y * `MVDM_IMG_DIM + x]);
    end
    return int'(img1[y * `MVDM_IMG_DIM + x]);
endfunction

// Unnormalized bilinear sample, weights sum to 256
function automatic int interp_sample(int list, mvdm_pkg::mv_s mv, int r, int c);
    int unit;
    int fx;
    int fy;
    int x;
    int y;
    unit = 1 << `MVDM_FRAC_W;
    fx   = int'(mv.frac_x);
    fy   = int'(mv.frac_y);
    x    = int'(mv.int_x) + c;
    y    = int'(mv.int_y) + r;
    return (unit - fx) * (unit - fy) * ref_pixel(list, y, x)
         + fx * (unit - fy) * ref_pixel(list, y, x + 1)
         + (unit - fx) * fy * ref_pixel(list, y + 1, x)
         + fx * fy * ref_pixel(list, y + 1, x + 1);
endfunction

// Mirrored 9-point search, first index wins a tie
function automatic logic [`MVDM_RESULT_W-1:0] expected_result(mvdm_pkg::mv_s mv0,
                                                               mvdm_pkg::mv_s mv1);
    int blk0 [0:`MVDM_BLK_DIM*`MVDM_BLK_DIM-1];
    int blk1 [0:`MVDM_BLK_DIM*`MVDM_BLK_DIM-1];
    int sad;
    int best;
    int best_k;
    int dx;
    int dy;
    int diff;
    for (int r = 0; r < `MVDM_BLK_DIM; r++) begin
        for (int c = 0; c < `MVDM_BLK_DIM; c++) begin
            blk0[r * `MVDM_BLK_DIM + c] = interp_sample(0, mv0, r, c);
            blk1[r * `MVDM_BLK_DIM + c] = interp_sample(1, mv1, r, c);
        end
    end
    best   = -1;
    best_k = 0;
    for (int k = 0; k < `MVDM_SEARCH_N; k++) begin
        dx  = k % 3;
        dy  = k / 3;
        sad = 0;
        for (int r = 0; r < `MVDM_SAD_DIM; r++) begin
            for (int c = 0; c < `MVDM_SAD_DIM; c++) begin
                diff = blk0[(dy + r) * `MVDM_BLK_DIM + dx + c]
                     - blk1[(2 - dy + r) * `MVDM_BLK_DIM + 2 - dx + c];
                sad += (diff < 0) ? -diff : diff;
            end
        end
        if (best < 0 || sad < best) begin
            best   = sad;
            best_k = k;
        end
    end
    return {best_k[`MVDM_IDX_W-1:0], best[`MVDM_SAD_W-1:0]};
endfunction

`endif

// ==== tb/tb_mvdm.sv ====
`timescale 1ns/1ps
`include "mvdm_config.svh"

module tb_mvdm;

    localparam int IMG_WORDS      = `MVDM_IMG_DIM * `MVDM_IMG_DIM;
    localparam int MV_MAX         = `MVDM_IMG_DIM - 13;    // Keeps the 11x11 window inside
    localparam int RESULT_TIMEOUT = 5000;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_valid2;
    mvdm_pkg::in_word_u in_data;
    logic               out_valid;
    logic               out_sad;

    logic [`MVDM_PIX_W-1:0]    img0 [0:IMG_WORDS-1];
    logic [`MVDM_PIX_W-1:0]    img1 [0:IMG_WORDS-1];
    logic                      mv_sent;
    int                        run_len;
    logic [`MVDM_RESULT_W-1:0] rx_word;
    logic [`MVDM_RESULT_W-1:0] results [$];

    `include "mvdm_model.svh"

    mvdm_top u_mvdm_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //==========================================================================
    //  Failure reporting
    //==========================================================================
    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s: expected %0h, actual %0h", test, expected, actual);
        $display("RESULT: FAIL");
        $fatal(1, "value mismatch in %s", test);
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "%s", msg);
    endtask

    //==========================================================================
    //  Output monitor
    //==========================================================================
    always @(posedge clk) begin
        if (rst_n) begin
            assert (mv_sent || (!out_valid && !out_sad))
                else report_mismatch("outputs_before_mv", 0, {out_valid, out_sad});
            assert (out_valid || !out_sad)
                else report_mismatch("out_sad_while_idle", 0, out_sad);
            if (out_valid) begin
                assert (run_len < `MVDM_RESULT_W)
                    else report_mismatch("burst_length", `MVDM_RESULT_W, run_len + 1);
                rx_word[run_len] = out_sad;    // LSB first
                run_len++;
            end else if (run_len != 0) begin
                assert (run_len == `MVDM_RESULT_W)
                    else report_mismatch("burst_length", `MVDM_RESULT_W, run_len);
                results.push_back(rx_word);
                run_len = 0;
            end
        end
    end

    //==========================================================================
    //  Stimulus
    //==========================================================================
    task automatic load_images(input bit same);
        for (int i = 0; i < IMG_WORDS; i++) begin
            img0[i] = 8'($urandom_range(0, 255));
            img1[i] = same ? img0[i] : 8'($urandom_range(0, 255));
        end
        for (int i = 0; i < 2 * IMG_WORDS; i++) begin
            @(negedge clk);
            in_valid                  = 1'b1;
            in_data.pixel_view.pix    = (i < IMG_WORDS) ? img0[i] : img1[i - IMG_WORDS];
            in_data.pixel_view.unused = 4'($urandom_range(0, 15));    // Junk the DUT drops
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    function automatic mvdm_pkg::mv_s random_mv();
        mvdm_pkg::mv_s mv;
        mv.int_x  = 7'($urandom_range(0, MV_MAX));
        mv.int_y  = 7'($urandom_range(0, MV_MAX));
        mv.frac_x = 4'($urandom_range(1, 15));
        mv.frac_y = 4'($urandom_range(1, 15));
        return mv;
    endfunction

    task automatic send_mvs(input mvdm_pkg::mv_s mv0, input mvdm_pkg::mv_s mv1);
        logic [6:0] pos  [0:3];
        logic [3:0] frac [0:3];
        pos  = '{mv0.int_x, mv0.int_y, mv1.int_x, mv1.int_y};
        frac = '{mv0.frac_x, mv0.frac_y, mv1.frac_x, mv1.frac_y};
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            in_valid2       = 1'b1;
            in_data.mv_view = '{spare: 1'b0, int_pos: pos[i], frac: frac[i]};
        end
        @(negedge clk);
        in_valid2 = 1'b0;
        in_data   = '0;
        mv_sent   = 1'b1;
    endtask

    task automatic run_search(input string test, input mvdm_pkg::mv_s mv0,
                              input mvdm_pkg::mv_s mv1,
                              input logic [`MVDM_RESULT_W-1:0] expected);
        int                        cycles;
        logic [`MVDM_RESULT_W-1:0] got;
        cycles = 0;
        send_mvs(mv0, mv1);
        while (results.size() == 0 && cycles < RESULT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (results.size() == 0) begin
            report_error({test, ": no complete result burst before the timeout"});
        end else begin
            got = results.pop_front();
            assert (got == expected) else report_mismatch(test, expected, got);
            repeat (2) @(negedge clk);    // Idle gap before next transfer
        end
    endtask

    //==========================================================================
    //  Test sequence
    //==========================================================================
    initial begin
        mvdm_pkg::mv_s mv_a;
        mvdm_pkg::mv_s mv_b;
        void'($urandom(32'h969f7d09));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_valid2 = 1'b0;
        in_data   = '0;
        mv_sent   = 1'b0;
        run_len   = 0;
        rx_word   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (20) @(negedge clk);    // Outputs stay quiet through the load

        load_images(1'b0);
        repeat (4) @(negedge clk);
        mv_a = random_mv();
        mv_b = random_mv();
        run_search("random_images", mv_a, mv_b, expected_result(mv_a, mv_b));

        // Fresh vectors on the same images
        for (int i = 0; i < 3; i++) begin
            mv_a = random_mv();
            mv_b = random_mv();
            run_search("rerun_same_images", mv_a, mv_b, expected_result(mv_a, mv_b));
        end

        // Center point mirrors onto itself
        load_images(1'b1);
        mv_a = random_mv();
        run_search("identical_lists", mv_a, mv_a, {4'd4, 24'd0});

        // Zero minimum of the last run must not carry over
        mv_a = random_mv();
        mv_b = random_mv();
        run_search("rerun_after_zero_sad", mv_a, mv_b, expected_result(mv_a, mv_b));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
+incdir+tb
verilog/mvdm_pkg.sv
verilog/pixel_ram.sv
verilog/mvdm_ctrl.sv
verilog/bilinear_interp.sv
verilog/sad_search.sv
verilog/mvdm_top.sv
tb/tb_mvdm.sv

// ==== Bender.yml ====
package:
  name: mvdm

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mvdm_pkg.sv
      - verilog/pixel_ram.sv
      - verilog/mvdm_ctrl.sv
      - verilog/bilinear_interp.sv
      - verilog/sad_search.sv
      - verilog/mvdm_top.sv
  - target: simulation
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_mvdm.sv
